// ==== hw/exec_pkg.sv ====
// Shared types for the execution back end
// Opcode enum and execution unit select enum
`default_nettype none

package exec_pkg;

    // Opcodes, ALU group first, multiplier group after
    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_AND    = 4'd2,
        OP_OR     = 4'd3,
        OP_XOR    = 4'd4,
        OP_SLT    = 4'd5,
        OP_SLTU   = 4'd6,
        OP_SLL    = 4'd7,
        OP_SRL    = 4'd8,
        OP_SRA    = 4'd9,
        OP_MUL    = 4'd10,
        OP_MULH   = 4'd11,
        OP_MULHSU = 4'd12,
        OP_MULHU  = 4'd13
    } op_t;

    // Target unit of a held instruction
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_sel_t;

endpackage

`default_nettype wire

// ==== hw/issue_stage.sv ====
// One-entry issue register with unit steering
`timescale 1ns/10ps
`default_nettype none

module issue_stage
    import exec_pkg::*;
#(
    parameter int XLEN     = 32,
    parameter int ID_WIDTH = 3
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                issue_valid,
    output logic                issue_ready,
    input  op_t                 issue_op,
    input  logic [XLEN-1:0]     issue_rs1,
    input  logic [XLEN-1:0]     issue_rs2,
    input  logic [ID_WIDTH-1:0] issue_id,
    output logic                alu_valid,
    input  logic                alu_ready,
    output logic                mul_valid,
    input  logic                mul_ready,
    output op_t                 unit_op,
    output logic [XLEN-1:0]     unit_rs1,
    output logic [XLEN-1:0]     unit_rs2,
    output logic [ID_WIDTH-1:0] unit_id
);

    logic      entry_valid;
    unit_sel_t entry_sel;
    logic      accept;
    logic      unit_take;

    assign accept    = issue_valid && issue_ready;
    assign unit_take = (alu_valid && alu_ready) || (mul_valid && mul_ready);

    // Entry frees up in the same cycle its unit takes it
    assign issue_ready = !entry_valid || unit_take;

    assign alu_valid = entry_valid && (entry_sel == UNIT_ALU);
    assign mul_valid = entry_valid && (entry_sel == UNIT_MUL);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry_valid <= 1'b0;
        end else if (accept) begin
            entry_valid <= 1'b1;
        end else if (unit_take) begin
            entry_valid <= 1'b0;
        end
    end

    // Held instruction, steered by opcode class
    always_ff @(posedge clk) begin
        if (accept) begin
            entry_sel <= (issue_op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU}) ?
                         UNIT_MUL : UNIT_ALU;
            unit_op   <= issue_op;
            unit_rs1  <= issue_rs1;
            unit_rs2  <= issue_rs2;
            unit_id   <= issue_id;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Assertions
    a_legal_op : assert property (@(posedge clk) disable iff (!arst_n)
        accept |-> issue_op inside {[OP_ADD:OP_MULHU]})
        else $error("issue_stage: accepted an unused opcode %0d", issue_op);

endmodule

`default_nettype wire

// ==== hw/alu_unit.sv ====
// Single-cycle integer ALU
// Result and id held in a register until the arbiter acknowledges
`timescale 1ns/10ps
`default_nettype none

module alu_unit
    import exec_pkg::*;
#(
    parameter int XLEN     = 32,
    parameter int ID_WIDTH = 3
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                valid,
    output logic                ready,
    input  op_t                 op,
    input  logic [XLEN-1:0]     rs1,
    input  logic [XLEN-1:0]     rs2,
    input  logic [ID_WIDTH-1:0] id,
    output logic                done,
    output logic [XLEN-1:0]     result,
    output logic [ID_WIDTH-1:0] done_id,
    input  logic                ack
);

    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_out;
    logic            take;

    assign shamt = rs2[4:0];
    assign take  = valid && ready;

    // Free when nothing is held or the held result leaves this cycle
    assign ready = !done || ack;

    ////////////////////////////////////////////////////////////////////
    // Datapath
    always_comb begin
        case (op)
            OP_ADD:  alu_out = rs1 + rs2;
            OP_SUB:  alu_out = rs1 - rs2;
            OP_AND:  alu_out = rs1 & rs2;
            OP_OR:   alu_out = rs1 | rs2;
            OP_XOR:  alu_out = rs1 ^ rs2;
            OP_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(rs1) < $signed(rs2)};
            OP_SLTU: alu_out = {{(XLEN-1){1'b0}}, rs1 < rs2};
            OP_SLL:  alu_out = rs1 << shamt;
            OP_SRL:  alu_out = rs1 >> shamt;
            // Sign bit shifted in
            OP_SRA:  alu_out = $unsigned($signed(rs1) >>> shamt);
            default: alu_out = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Result register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (take) begin
            done <= 1'b1;
        end else if (ack) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            result  <= alu_out;
            done_id <= id;
        end
    end

    a_ack_needs_done : assert property (@(posedge clk) disable iff (!arst_n)
        ack |-> done)
        else $error("alu_unit: ack without a held result");

endmodule

`default_nettype wire

// ==== hw/mul_unit.sv ====
// Two-stage multiplier pipeline
// Stage 1 forms the full product, stage 2 picks the half and holds it
`timescale 1ns/10ps
`default_nettype none

module mul_unit
    import exec_pkg::*;
#(
    parameter int XLEN     = 32,
    parameter int ID_WIDTH = 3
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                valid,
    output logic                ready,
    input  op_t                 op,
    input  logic [XLEN-1:0]     rs1,
    input  logic [XLEN-1:0]     rs2,
    input  logic [ID_WIDTH-1:0] id,
    output logic                done,
    output logic [XLEN-1:0]     result,
    output logic [ID_WIDTH-1:0] done_id,
    input  logic                ack
);

    logic                  rs1_signed;
    logic                  rs2_signed;
    logic signed [XLEN:0]  rs1_ext;
    logic signed [XLEN:0]  rs2_ext;
    logic [2*XLEN-1:0]     product;

    logic                  s1_valid;
    op_t                   s1_op;
    logic [ID_WIDTH-1:0]   s1_id;
    logic [2*XLEN-1:0]     s1_product;

    logic                  take;
    logic                  s2_free;
    logic                  s1_move;

    ////////////////////////////////////////////////////////////////////
    // Operand extension by opcode
    assign rs1_signed = (op == OP_MULH) || (op == OP_MULHSU);
    assign rs2_signed = (op == OP_MULH);
    assign rs1_ext    = {rs1_signed & rs1[XLEN-1], rs1};
    assign rs2_ext    = {rs2_signed & rs2[XLEN-1], rs2};
    assign product    = rs1_ext * rs2_ext;

    // A stage moves on only into an empty or emptying stage
    assign s2_free = !done || ack;
    assign s1_move = s1_valid && s2_free;
    assign ready   = !s1_valid || s2_free;
    assign take    = valid && ready;

    ////////////////////////////////////////////////////////////////////
    // Stage 1
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else if (take) begin
            s1_valid <= 1'b1;
        end else if (s1_move) begin
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            s1_op      <= op;
            s1_id      <= id;
            s1_product <= product;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Stage 2, held until acknowledged
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (s1_move) begin
            done <= 1'b1;
        end else if (ack) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_move) begin
            result  <= (s1_op == OP_MUL) ? s1_product[XLEN-1:0] :
                                           s1_product[2*XLEN-1:XLEN];
            done_id <= s1_id;
        end
    end

    a_ack_needs_done : assert property (@(posedge clk) disable iff (!arst_n)
        ack |-> done)
        else $error("mul_unit: ack without a held result");

    // A stalled instruction must wait unchanged at the input
    a_stall_stable : assert property (@(posedge clk) disable iff (!arst_n)
        valid && !ready |=> valid && $stable(id) && $stable(op))
        else $error("mul_unit: offered instruction changed while stalled");

endmodule

`default_nettype wire

// ==== hw/writeback_arbiter.sv ====
// Fixed-priority writeback arbiter, multiplier over ALU
// Registered single writeback port
`timescale 1ns/10ps
`default_nettype none

module writeback_arbiter #(
    parameter int XLEN     = 32,
    parameter int ID_WIDTH = 3
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                alu_done,
    input  logic [XLEN-1:0]     alu_result,
    input  logic [ID_WIDTH-1:0] alu_id,
    output logic                alu_ack,
    input  logic                mul_done,
    input  logic [XLEN-1:0]     mul_result,
    input  logic [ID_WIDTH-1:0] mul_id,
    output logic                mul_ack,
    output logic                wb_valid,
    output logic [ID_WIDTH-1:0] wb_id,
    output logic [XLEN-1:0]     wb_data
);

    logic grant;

    // Multiplier always wins, ALU only when it is alone
    assign mul_ack = mul_done;
    assign alu_ack = alu_done && !mul_done;
    assign grant   = mul_ack || alu_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= grant;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            wb_id   <= mul_ack ? mul_id : alu_id;
            wb_data <= mul_ack ? mul_result : alu_result;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Assertions
    // A losing ALU result waits unchanged for its turn
    a_alu_hold : assert property (@(posedge clk) disable iff (!arst_n)
        alu_done && !alu_ack |=> alu_done && $stable(alu_id) && $stable(alu_result))
        else $error("writeback_arbiter: stalled ALU result changed before ack");

endmodule

`default_nettype wire

// ==== hw/exec_core.sv ====
// Execution back end top level
// Issue stage, ALU, multiplier and writeback arbiter
`timescale 1ns/10ps
`default_nettype none

module exec_core
    import exec_pkg::*;
#(
    parameter int XLEN     = 32,
    parameter int ID_WIDTH = 3
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                issue_valid,
    output logic                issue_ready,
    input  op_t                 issue_op,
    input  logic [XLEN-1:0]     issue_rs1,
    input  logic [XLEN-1:0]     issue_rs2,
    input  logic [ID_WIDTH-1:0] issue_id,
    output logic                wb_valid,
    output logic [ID_WIDTH-1:0] wb_id,
    output logic [XLEN-1:0]     wb_data
);

    ////////////////////////////////////////////////////////////////////
    // Unit issue lines, shared operands
    logic                alu_valid;
    logic                alu_ready;
    logic                mul_valid;
    logic                mul_ready;
    op_t                 unit_op;
    logic [XLEN-1:0]     unit_rs1;
    logic [XLEN-1:0]     unit_rs2;
    logic [ID_WIDTH-1:0] unit_id;

    // Unit writeback lines
    logic                alu_done;
    logic [XLEN-1:0]     alu_result;
    logic [ID_WIDTH-1:0] alu_done_id;
    logic                alu_ack;
    logic                mul_done;
    logic [XLEN-1:0]     mul_result;
    logic [ID_WIDTH-1:0] mul_done_id;
    logic                mul_ack;

    issue_stage #(.XLEN(XLEN), .ID_WIDTH(ID_WIDTH)) i_issue_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_id    (issue_id),
        .alu_valid   (alu_valid),
        .alu_ready   (alu_ready),
        .mul_valid   (mul_valid),
        .mul_ready   (mul_ready),
        .unit_op     (unit_op),
        .unit_rs1    (unit_rs1),
        .unit_rs2    (unit_rs2),
        .unit_id     (unit_id)
    );

    alu_unit #(.XLEN(XLEN), .ID_WIDTH(ID_WIDTH)) i_alu_unit (
        .clk     (clk),
        .arst_n  (arst_n),
        .valid   (alu_valid),
        .ready   (alu_ready),
        .op      (unit_op),
        .rs1     (unit_rs1),
        .rs2     (unit_rs2),
        .id      (unit_id),
        .done    (alu_done),
        .result  (alu_result),
        .done_id (alu_done_id),
        .ack     (alu_ack)
    );

    mul_unit #(.XLEN(XLEN), .ID_WIDTH(ID_WIDTH)) i_mul_unit (
        .clk     (clk),
        .arst_n  (arst_n),
        .valid   (mul_valid),
        .ready   (mul_ready),
        .op      (unit_op),
        .rs1     (unit_rs1),
        .rs2     (unit_rs2),
        .id      (unit_id),
        .done    (mul_done),
        .result  (mul_result),
        .done_id (mul_done_id),
        .ack     (mul_ack)
    );

    writeback_arbiter #(.XLEN(XLEN), .ID_WIDTH(ID_WIDTH)) i_writeback_arbiter (
        .clk        (clk),
        .arst_n     (arst_n),
        .alu_done   (alu_done),
        .alu_result (alu_result),
        .alu_id     (alu_done_id),
        .alu_ack    (alu_ack),
        .mul_done   (mul_done),
        .mul_result (mul_result),
        .mul_id     (mul_done_id),
        .mul_ack    (mul_ack),
        .wb_valid   (wb_valid),
        .wb_id      (wb_id),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// ==== dv/tb_exec_core.sv ====
// Testbench for exec_core
// Case file reader, id scoreboard, writeback monitor, watchdog and report
`timescale 1ns/10ps
`default_nettype none

module tb_exec_core
    import exec_pkg::*;
();

    localparam int    XLEN               = 32;
    localparam int    ID_WIDTH           = 3;
    localparam int    NUM_IDS            = 2**ID_WIDTH;
    localparam int    MAX_CASES          = 64;
    localparam time   CLK_PERIOD         = 20ns;
    localparam time   DRIVE_DELAY        = 2ns;
    localparam int    RESET_CYCLES       = 8;
    localparam int    WD_CYCLES_PER_CASE = 10;
    localparam int    WD_MARGIN_CYCLES   = 200;
    localparam int    DRAIN_CYCLES       = 10;
    localparam string CASES_FILE         = "dv/exec_cases.txt";

    logic                clk;
    logic                arst_n;
    logic                issue_valid;
    logic                issue_ready;
    op_t                 issue_op;
    logic [XLEN-1:0]     issue_rs1;
    logic [XLEN-1:0]     issue_rs2;
    logic [ID_WIDTH-1:0] issue_id;
    logic                wb_valid;
    logic [ID_WIDTH-1:0] wb_id;
    logic [XLEN-1:0]     wb_data;

    // Cases as read from the file
    string           case_name [MAX_CASES];
    logic [7:0]      case_op   [MAX_CASES];
    logic [XLEN-1:0] case_a    [MAX_CASES];
    logic [XLEN-1:0] case_b    [MAX_CASES];
    logic [XLEN-1:0] case_exp  [MAX_CASES];
    int              num_cases;

    // Scoreboard indexed by id
    bit              sb_busy [NUM_IDS];
    string           sb_name [NUM_IDS];
    logic [XLEN-1:0] sb_exp  [NUM_IDS];

    logic [ID_WIDTH-1:0] next_id;
    integer              seed;
    int                  pass_count;
    int                  fail_count;
    int                  done_count;
    int                  total_issues;
    bit                  cases_loaded;

    exec_core #(.XLEN(XLEN), .ID_WIDTH(ID_WIDTH)) i_exec_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_id    (issue_id),
        .wb_valid    (wb_valid),
        .wb_id       (wb_id),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    task automatic read_cases();
        integer     fd;
        int         n;
        string      line;
        string      nm;
        logic [7:0] op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] e;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            fail_count++;
            $display("Could not open the case file %s", CASES_FILE);
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // Skip comment and blank lines
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%s %h %h %h %h", nm, op, a, b, e);
            if (n != 5 || num_cases >= MAX_CASES) begin
                fail_count++;
                $display("Could not use case line: %s", line);
            end else begin
                case_name[num_cases] = nm;
                case_op[num_cases]   = op;
                case_a[num_cases]    = a;
                case_b[num_cases]    = b;
                case_exp[num_cases]  = e;
                num_cases++;
            end
        end
        $fclose(fd);
        if (num_cases == 0) begin
            fail_count++;
            $display("The case file holds no usable cases");
        end
    endtask

    task automatic check_reset_idle();
        bit ok;
        ok = 1'b1;
        repeat (4) begin
            @(negedge clk);
            assert (!wb_valid && issue_ready)
            else begin
                ok = 1'b0;
                $display("FAIL reset_idle: writeback active or issue port not ready after reset");
            end
        end
        if (ok) begin
            pass_count++;
            $display("PASS reset_idle");
        end else begin
            fail_count++;
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Called DRIVE_DELAY after a rising edge, returns likewise
    task automatic issue_case(input int idx);
        bit accepted;
        while (sb_busy[next_id]) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        sb_busy[next_id] = 1'b1;
        sb_name[next_id] = case_name[idx];
        sb_exp[next_id]  = case_exp[idx];
        issue_valid = 1'b1;
        issue_op    = op_t'(case_op[idx][3:0]);
        issue_rs1   = case_a[idx];
        issue_rs2   = case_b[idx];
        issue_id    = next_id;
        do begin
            @(negedge clk);
            accepted = issue_ready;
            @(posedge clk);
            #DRIVE_DELAY;
        end while (!accepted);
        issue_valid = 1'b0;
        next_id     = next_id + 1'b1;
    endtask

    task automatic run_pass(input bit with_gaps);
        int i;
        int gap;
        for (i = 0; i < num_cases; i++) begin
            issue_case(i);
            gap = with_gaps ? ($random(seed) & 3) : 0;
            repeat (gap) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Writeback monitor
    always @(negedge clk) begin
        if (arst_n && wb_valid) begin
            assert (sb_busy[wb_id])
            else begin
                fail_count++;
                $display("FAIL writeback for id %0d with no test outstanding on it", wb_id);
            end
            if (sb_busy[wb_id]) begin
                assert (wb_data === sb_exp[wb_id])
                else begin
                    fail_count++;
                    $display("ERROR %s expected %h actual %h",
                             sb_name[wb_id], sb_exp[wb_id], wb_data);
                end
                if (wb_data === sb_exp[wb_id]) begin
                    pass_count++;
                    $display("PASS %s id %0d data %h", sb_name[wb_id], wb_id, wb_data);
                end
                sb_busy[wb_id] = 1'b0;
                done_count++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        arst_n       = 1'b0;
        issue_valid  = 1'b0;
        issue_op     = OP_ADD;
        issue_rs1    = '0;
        issue_rs2    = '0;
        issue_id     = '0;
        next_id      = '0;
        seed         = 32'h4e1a;
        pass_count   = 0;
        fail_count   = 0;
        done_count   = 0;
        num_cases    = 0;
        cases_loaded = 1'b0;
        for (int k = 0; k < NUM_IDS; k++) sb_busy[k] = 1'b0;
        read_cases();
        // First pass back to back, second pass with random idle gaps
        total_issues = 2 * num_cases;
        cases_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        check_reset_idle();
        run_pass(1'b0);
        run_pass(1'b1);
        while (done_count < total_issues) @(posedge clk);
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("Passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog, scaled by the number of issues
    initial begin
        wait (cases_loaded);
        repeat (total_issues * WD_CYCLES_PER_CASE + WD_MARGIN_CYCLES) @(posedge clk);
        fail_count++;
        $display("Watchdog expired, the run did not finish in time");
        for (int k = 0; k < NUM_IDS; k++) begin
            if (sb_busy[k]) begin
                fail_count++;
                $display("Test %s with id %0d never wrote back", sb_name[k], k);
            end
        end
        $display("Passed %0d, failed %0d", pass_count, fail_count);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/exec_pkg.sv
hw/issue_stage.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/writeback_arbiter.sv
hw/exec_core.sv
dv/tb_exec_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the exec_core testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_exec_core -f list.f -o tb_exec_core \
    && ./obj_dir/tb_exec_core 2>&1 | tee "$LOG" \
    || echo "Simulation build or run did not complete"

# A missing log or a missing pass line also counts as failure
grep -q "TESTS FAILED" "$LOG" && exit 1
grep -q "TESTS PASSED" "$LOG" || exit 1
exit 0

// ==== dv/exec_cases.txt ====
# name  opcode  operand1  operand2  expected   (every column after the name in hex)
# opcodes 0 to 9 go to the ALU, a to d to the multiplier
add_basic      0 00000005 00000007 0000000c
add_wrap       0 ffffffff 00000002 00000001
sub_neg        1 00000003 00000005 fffffffe
and_mask       2 f0f0f0f0 0ff00ff0 00f000f0
or_bits        3 f0f0f0f0 0ff00ff0 fff0fff0
xor_bits       4 f0f0f0f0 0ff00ff0 ff00ff00
slt_signed     5 ffffffff 00000001 00000001
sltu_unsigned  6 ffffffff 00000001 00000000
slt_min        5 80000000 7fffffff 00000001
sll_low_five   7 00000001 00000024 00000010
srl_neg        8 80000000 00000004 08000000
sra_neg        9 80000000 00000004 f8000000
mul_neg        a fffffffe 00000003 fffffffa
mulh_neg       b fffffffe 00000003 ffffffff
mulhsu_neg     c ffffffff ffffffff ffffffff
mulhu_all_one  d ffffffff ffffffff fffffffe
mulh_min       b 80000000 80000000 40000000
mulhu_carry    d 80000000 00000002 00000001
